// File: tb/kerbin_vectors.txt
# master op addr data strb exp_data exp_resp   (hex except master)
# op W writes data under strb, op R expects exp_data; resp 0 is OKAY, 3 is DECERR
0 W 00000010 11223344 f 00000000 0
0 W 00000010 aabbccdd 5 00000000 0
0 R 00000010 00000000 0 11bb33dd 0
0 W 00000ffc 01020304 f 00000000 0
0 R 00000ffc 00000000 0 01020304 0
0 R 00001000 00000000 0 00000000 3
1 W 00000800 deadbeef f 00000000 0
1 W 00000800 00005500 2 00000000 0
1 R 00000800 00000000 0 dead55ef 0
1 W 80000000 12345678 f 00000000 3
1 W 00000804 cafef00d f 00000000 0
1 R 00000804 00000000 0 cafef00d 0
1 R ffff0000 00000000 0 00000000 3

// File: src.f
rtl/kerbin_pkg.sv
rtl/kerbin_reset_seq.sv
rtl/kerbin_axil_xbar.sv
rtl/kerbin_axil_slice.sv
rtl/kerbin_soc_mem.sv
rtl/kerbin.sv
tb/tb_kerbin.sv

// File: run.sh
#!/bin/sh
# build the kerbin testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_kerbin -f src.f -o tb_kerbin

out=$(./obj_dir/tb_kerbin)
echo "$out"

# pass only when the testbench printed the pass line
echo "$out" | grep -qx "Everything OK"

// File: tb/tb_kerbin.sv
// testbench for the kerbin fabric that checks reset timing and runs two master streams from the vector file
`timescale 1ns/1ns

module tb_kerbin;
    import kerbin_pkg::*;

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 80;   // board reset, lock wait and both releases
    localparam int cycles_per_line = 200;

    // one line of the vector file
    typedef struct packed {
        logic [7:0] op;        // ascii W or R
        addr_t      addr;
        data_t      data;
        strb_t      strb;
        data_t      exp_data;
        resp_t      exp_resp;
    } vec_t;

    logic      clk;
    logic      rst_n;
    logic      lock;
    axil_req_t m0_req;
    axil_req_t m1_req;
    axil_rsp_t m0_rsp;
    axil_rsp_t m1_rsp;
    logic      rst_bus_n;
    logic      rst_core_n;
    vec_t      q0[$];   // master 0 lines in file order
    vec_t      q1[$];
    int        errors;
    int        checks;

    kerbin i_kerbin (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .lock_i       ( lock       ),
        .m0_req_i     ( m0_req     ),
        .m1_req_i     ( m1_req     ),
        .m0_rsp_o     ( m0_rsp     ),
        .m1_rsp_o     ( m1_rsp     ),
        .rst_bus_n_o  ( rst_bus_n  ),
        .rst_core_n_o ( rst_core_n )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: resp expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: data expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            $display("FAIL %s: cycles expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        errors++;
    endtask

    // --------------------------------------------------
    // vector file and watchdog
    // --------------------------------------------------
    task automatic load_vectors();
        int         fd;
        int         n;
        int         m;
        logic [7:0] op;
        addr_t      addr;
        data_t      data;
        strb_t      strb;
        data_t      exp_d;
        resp_t      exp_r;
        string      line;
        fd = $fopen("tb/kerbin_vectors.txt", "r");
        if (fd == 0) begin
            report_error("cannot open the vector file tb/kerbin_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
                n = $sscanf(line, "%d %c %h %h %h %h %h", m, op, addr, data, strb, exp_d, exp_r);
                if (n != 7 || (op != "W" && op != "R") || m < 0 || m > 1) begin
                    report_error($sformatf("vector line not understood: %s", line));
                end else if (m == 0) begin
                    q0.push_back({op, addr, data, strb, exp_d, exp_r});
                end else begin
                    q1.push_back({op, addr, data, strb, exp_d, exp_r});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic watchdog();
        int limit;
        limit = cycles_per_line * (q0.size() + q1.size()) + reset_cycles;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the run never reached its end", limit);
        $display("Something failed");
        $finish;
    endtask

    // --------------------------------------------------
    // master drivers
    // --------------------------------------------------
    task automatic drive_req(input int m, input axil_req_t req);
        if (m == 0) m0_req <= req;
        else m1_req <= req;
    endtask

    task automatic run_txn(input int m, input vec_t v);
        axil_req_t req;
        axil_rsp_t rsp;
        axil_rsp_t held;
        logic      held_ok;
        logic      got;
        int        stall;
        string     name;
        name = $sformatf("m%0d %s %h", m, (v.op == "W") ? "write" : "read", v.addr);
        req = '0;
        if (v.op == "W") begin
            req.aw_valid = 1'b1;
            req.aw_addr  = v.addr;
            req.w_valid  = 1'b1;
            req.w_data   = v.data;
            req.w_strb   = v.strb;
        end else begin
            req.ar_valid = 1'b1;
            req.ar_addr  = v.addr;
        end
        stall       = $urandom % 6;   // cycles of back-pressure on the answer
        req.b_ready = (stall == 0);
        req.r_ready = (stall == 0);
        held_ok     = 1'b0;
        got         = 1'b0;
        drive_req(m, req);
        while (!got) begin
            @(posedge clk);
            rsp = (m == 0) ? m0_rsp : m1_rsp;  // values before this edge
            if (held_ok && rsp !== held)
                report_error($sformatf("%s: stalled response dropped or changed", name));
            held_ok = 1'b0;
            if ((rsp.b_valid || rsp.r_valid) && (req.aw_valid || req.w_valid || req.ar_valid))
                report_error($sformatf("%s: response before request accepted", name));
            if (req.aw_valid && rsp.aw_ready) req.aw_valid = 1'b0;
            if (req.w_valid && rsp.w_ready) req.w_valid = 1'b0;
            if (req.ar_valid && rsp.ar_ready) req.ar_valid = 1'b0;
            if ((rsp.b_valid && req.b_ready) || (rsp.r_valid && req.r_ready)) begin
                got = 1'b1;
                if (v.op == "W" && !rsp.b_valid)
                    report_error($sformatf("%s: write answered on the read channel", name));
                else if (v.op == "R" && !rsp.r_valid)
                    report_error($sformatf("%s: read answered on the write channel", name));
                else if (v.op == "W")
                    check_resp(name, v.exp_resp, rsp.b_resp);
                else begin
                    check_resp(name, v.exp_resp, rsp.r_resp);
                    check_data(name, v.exp_data, rsp.r_data);
                end
                req = '0;
            end else if (rsp.b_valid || rsp.r_valid) begin
                held    = rsp;                 // must survive until ready
                held_ok = 1'b1;
                if (stall > 0) stall--;
                req.b_ready = (stall == 0);
                req.r_ready = (stall == 0);
            end
            drive_req(m, req);
        end
    endtask

    task automatic run_stream(input int m);
        int n;
        n = (m == 0) ? q0.size() : q1.size();
        for (int i = 0; i < n; i++) begin
            run_txn(m, (m == 0) ? q0[i] : q1[i]);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        time t_lock;
        time t_bus;
        time t_drop;
        rst_n  = 1'b0;
        lock   = 1'b0;
        m0_req = '0;
        m1_req = '0;
        errors = 0;
        checks = 0;
        void'($urandom(32'h7272_6b64));
        load_vectors();
        fork
            watchdog();
        join_none
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);
        lock <= 1'b1;
        @(posedge clk);
        t_lock = $time;                        // first edge that sees lock
        @(posedge rst_bus_n);
        t_bus = $time;
        check_cycles("bus reset release", K_LOCK_HOLD_CYCLES, int'((t_bus - t_lock) / clk_period));
        @(posedge rst_core_n);
        check_cycles("core reset release", K_CORE_DELAY_CYCLES,
                     int'(($time - t_bus) / clk_period));
        @(posedge clk);
        fork
            run_stream(0);
            run_stream(1);
        join
        repeat (4) begin
            @(posedge clk);
            if (m0_rsp.b_valid || m0_rsp.r_valid || m1_rsp.b_valid || m1_rsp.r_valid)
                report_error("extra response seen after all transactions completed");
        end
        t_drop = $time;
        lock  <= 1'b0;                         // lose lock once
        wait (!rst_bus_n && !rst_core_n);
        check_cycles("reset on lock loss", 1, int'(($time - t_drop) / clk_period));
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rtl/kerbin.sv
// kerbin fabric top level: reset sequencer, crossbar, register slice and on-chip memory
`timescale 1ns/1ns

module kerbin (
    input  logic                  clk_i,
    input  logic                  rst_n_i,       // board reset
    input  logic                  lock_i,        // clock lock from outside
    input  kerbin_pkg::axil_req_t m0_req_i,      // instruction port
    input  kerbin_pkg::axil_req_t m1_req_i,      // data port
    output kerbin_pkg::axil_rsp_t m0_rsp_o,
    output kerbin_pkg::axil_rsp_t m1_rsp_o,
    output logic                  rst_bus_n_o,
    output logic                  rst_core_n_o   // masters start after this
);
    import kerbin_pkg::*;

    logic      rst_bus_n;
    axil_req_t mem_req;
    axil_rsp_t mem_rsp;
    axil_req_t slice_req;
    axil_rsp_t slice_rsp;

    assign rst_bus_n_o = rst_bus_n;

    // --------------------------------------------------
    // reset and interconnect
    // --------------------------------------------------
    kerbin_reset_seq i_kerbin_reset_seq (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .lock_i       ( lock_i       ),
        .rst_bus_n_o  ( rst_bus_n    ),
        .rst_core_n_o ( rst_core_n_o )
    );

    kerbin_axil_xbar i_kerbin_axil_xbar (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_bus_n ),
        .m0_req_i  ( m0_req_i  ),
        .m0_rsp_o  ( m0_rsp_o  ),
        .m1_req_i  ( m1_req_i  ),
        .m1_rsp_o  ( m1_rsp_o  ),
        .mem_req_o ( mem_req   ),
        .mem_rsp_i ( mem_rsp   )
    );

    kerbin_axil_slice i_kerbin_axil_slice (  // timing relief towards memory
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_bus_n ),
        .req_i   ( mem_req   ),
        .rsp_o   ( mem_rsp   ),
        .req_o   ( slice_req ),
        .rsp_i   ( slice_rsp )
    );

    kerbin_soc_mem i_kerbin_soc_mem (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_bus_n ),
        .req_i   ( slice_req ),
        .rsp_o   ( slice_rsp )
    );

endmodule

// File: rtl/kerbin_soc_mem.sv
// on-chip AXI4-Lite word memory with byte strobes, stands in for the DDR3 controller
`timescale 1ns/1ns

module kerbin_soc_mem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  kerbin_pkg::axil_req_t req_i,
    output kerbin_pkg::axil_rsp_t rsp_o
);
    import kerbin_pkg::*;

    data_t                      mem_q [K_MEM_WORDS];
    data_t                      r_data_q;
    logic                       b_valid_q;
    logic                       r_valid_q;
    logic                       wr_go;
    logic                       rd_go;
    addr_t                      wr_off;
    addr_t                      rd_off;
    logic [K_MEM_IDX_WIDTH-1:0] wr_idx;
    logic [K_MEM_IDX_WIDTH-1:0] rd_idx;

    // AW and W taken together, nothing new while a response waits
    assign wr_go = req_i.aw_valid & req_i.w_valid & ~b_valid_q;
    assign rd_go = req_i.ar_valid & ~r_valid_q;

    assign wr_off = req_i.aw_addr - K_MEM_BASE;
    assign rd_off = req_i.ar_addr - K_MEM_BASE;
    assign wr_idx = wr_off[K_MEM_IDX_WIDTH+1:2];  // word index
    assign rd_idx = rd_off[K_MEM_IDX_WIDTH+1:2];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (wr_go) b_valid_q <= 1'b1;
            else if (req_i.b_ready) b_valid_q <= 1'b0;
            if (rd_go) r_valid_q <= 1'b1;
            else if (req_i.r_ready) r_valid_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_go) begin
            for (int i = 0; i < K_STRB_WIDTH; i++) begin
                if (req_i.w_strb[i]) mem_q[wr_idx][8*i +: 8] <= req_i.w_data[8*i +: 8];
            end
        end
        if (rd_go) r_data_q <= mem_q[rd_idx];  // old word on same-cycle write
    end

    always_comb begin
        rsp_o          = '0;
        rsp_o.aw_ready = wr_go;
        rsp_o.w_ready  = wr_go;
        rsp_o.b_valid  = b_valid_q;
        rsp_o.b_resp   = K_RESP_OKAY;
        rsp_o.ar_ready = rd_go;
        rsp_o.r_valid  = r_valid_q;
        rsp_o.r_data   = r_data_q;
        rsp_o.r_resp   = K_RESP_OKAY;
    end

endmodule

// File: rtl/kerbin_axil_slice.sv
// AXI4-Lite register slice for the memory path, one pipeline stage on each of the five channels
`timescale 1ns/1ns

module kerbin_axil_slice_stage #(
    parameter int unsigned WIDTH = 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_o,
    input  logic             ready_i,
    output logic [WIDTH-1:0] data_o
);
    logic             full_q;
    logic [WIDTH-1:0] data_q;

    assign ready_o = ~full_q | ready_i;  // refill while the held item leaves
    assign valid_o = full_q;
    assign data_o  = data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) data_q <= data_i;  // payload only
    end

    // held item neither drops nor changes before it is taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

module kerbin_axil_slice (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  kerbin_pkg::axil_req_t req_i,
    output kerbin_pkg::axil_rsp_t rsp_o,
    output kerbin_pkg::axil_req_t req_o,
    input  kerbin_pkg::axil_rsp_t rsp_i
);
    import kerbin_pkg::*;

    // --------------------------------------------------
    // forward channels
    // --------------------------------------------------
    kerbin_axil_slice_stage #(.WIDTH($bits(addr_t))) i_aw (
        .clk_i, .rst_n_i,
        .valid_i (req_i.aw_valid), .ready_o (rsp_o.aw_ready), .data_i (req_i.aw_addr),
        .valid_o (req_o.aw_valid), .ready_i (rsp_i.aw_ready), .data_o (req_o.aw_addr)
    );

    kerbin_axil_slice_stage #(.WIDTH($bits(data_t) + $bits(strb_t))) i_w (
        .clk_i, .rst_n_i,
        .valid_i (req_i.w_valid), .ready_o (rsp_o.w_ready),
        .data_i  ({req_i.w_data, req_i.w_strb}),
        .valid_o (req_o.w_valid), .ready_i (rsp_i.w_ready),
        .data_o  ({req_o.w_data, req_o.w_strb})
    );

    kerbin_axil_slice_stage #(.WIDTH($bits(addr_t))) i_ar (
        .clk_i, .rst_n_i,
        .valid_i (req_i.ar_valid), .ready_o (rsp_o.ar_ready), .data_i (req_i.ar_addr),
        .valid_o (req_o.ar_valid), .ready_i (rsp_i.ar_ready), .data_o (req_o.ar_addr)
    );

    // --------------------------------------------------
    // response channels
    // --------------------------------------------------
    kerbin_axil_slice_stage #(.WIDTH($bits(resp_t))) i_b (
        .clk_i, .rst_n_i,
        .valid_i (rsp_i.b_valid), .ready_o (req_o.b_ready), .data_i (rsp_i.b_resp),
        .valid_o (rsp_o.b_valid), .ready_i (req_i.b_ready), .data_o (rsp_o.b_resp)
    );

    kerbin_axil_slice_stage #(.WIDTH($bits(data_t) + $bits(resp_t))) i_r (
        .clk_i, .rst_n_i,
        .valid_i (rsp_i.r_valid), .ready_o (req_o.r_ready),
        .data_i  ({rsp_i.r_data, rsp_i.r_resp}),
        .valid_o (rsp_o.r_valid), .ready_i (req_i.r_ready),
        .data_o  ({rsp_o.r_data, rsp_o.r_resp})
    );

endmodule

// File: rtl/kerbin_axil_xbar.sv
// AXI4-Lite crossbar: round-robin arbitration of two masters onto the memory port or a decode-error responder
`timescale 1ns/1ns

module kerbin_axil_xbar (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  kerbin_pkg::axil_req_t m0_req_i,
    output kerbin_pkg::axil_rsp_t m0_rsp_o,
    input  kerbin_pkg::axil_req_t m1_req_i,
    output kerbin_pkg::axil_rsp_t m1_rsp_o,
    output kerbin_pkg::axil_req_t mem_req_o,
    input  kerbin_pkg::axil_rsp_t mem_rsp_i
);
    import kerbin_pkg::*;

    xbar_state_e             state_q;
    logic [K_NR_MASTERS-1:0] grant_q;    // one-hot, zero when idle
    logic [K_NR_MASTERS-1:0] pend;
    logic                    prio_q;     // master that wins a tie
    logic                    is_write_q;
    logic                    decerr_q;   // current transaction is unmapped
    logic                    err_rdy_q;  // delays the decode-error answer
    logic                    aw_done_q;
    logic                    w_done_q;
    logic                    sel;
    logic                    cur_idx;
    logic                    cur_wr;
    addr_t                   dec_addr;
    logic                    in_range;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    ar_hs;
    logic                    done;
    axil_req_t               cur_req;
    axil_rsp_t               gnt_rsp;

    // --------------------------------------------------
    // arbitration and decode
    // --------------------------------------------------
    assign pend[0] = m0_req_i.aw_valid | m0_req_i.ar_valid;
    assign pend[1] = m1_req_i.aw_valid | m1_req_i.ar_valid;
    assign sel     = pend[1] & (prio_q | ~pend[0]);
    assign cur_idx = (state_q == XB_IDLE) ? sel : grant_q[1];
    assign cur_req = cur_idx ? m1_req_i : m0_req_i;

    assign cur_wr   = cur_req.aw_valid;  // write wins over read of same master
    assign dec_addr = cur_wr ? cur_req.aw_addr : cur_req.ar_addr;
    assign in_range = (dec_addr - K_MEM_BASE) <= (K_MEM_END - K_MEM_BASE);  // wraps below base

    // --------------------------------------------------
    // response seen by the granted master
    // --------------------------------------------------
    always_comb begin
        gnt_rsp          = '0;
        gnt_rsp.aw_ready = (state_q == XB_WRITE) & ~aw_done_q & (decerr_q | mem_rsp_i.aw_ready);
        gnt_rsp.w_ready  = (state_q == XB_WRITE) & ~w_done_q & (decerr_q | mem_rsp_i.w_ready);
        gnt_rsp.ar_ready = (state_q == XB_READ) & (decerr_q | mem_rsp_i.ar_ready);
        if (state_q == XB_RESP) begin
            gnt_rsp.b_valid = is_write_q & (decerr_q ? err_rdy_q : mem_rsp_i.b_valid);
            gnt_rsp.r_valid = ~is_write_q & (decerr_q ? err_rdy_q : mem_rsp_i.r_valid);
        end
        gnt_rsp.b_resp = decerr_q ? K_RESP_DECERR : mem_rsp_i.b_resp;
        gnt_rsp.r_resp = decerr_q ? K_RESP_DECERR : mem_rsp_i.r_resp;
        gnt_rsp.r_data = decerr_q ? '0 : mem_rsp_i.r_data;
    end

    assign m0_rsp_o = grant_q[0] ? gnt_rsp : '0;  // losing master sees nothing
    assign m1_rsp_o = grant_q[1] ? gnt_rsp : '0;

    // memory port only carries mapped traffic
    always_comb begin
        mem_req_o          = cur_req;
        mem_req_o.aw_valid = (state_q == XB_WRITE) & ~decerr_q & ~aw_done_q & cur_req.aw_valid;
        mem_req_o.w_valid  = (state_q == XB_WRITE) & ~decerr_q & ~w_done_q & cur_req.w_valid;
        mem_req_o.ar_valid = (state_q == XB_READ) & ~decerr_q & cur_req.ar_valid;
        mem_req_o.b_ready  = (state_q == XB_RESP) & ~decerr_q & is_write_q & cur_req.b_ready;
        mem_req_o.r_ready  = (state_q == XB_RESP) & ~decerr_q & ~is_write_q & cur_req.r_ready;
    end

    assign aw_hs = gnt_rsp.aw_ready & cur_req.aw_valid;
    assign w_hs  = gnt_rsp.w_ready & cur_req.w_valid;
    assign ar_hs = gnt_rsp.ar_ready & cur_req.ar_valid;
    assign done  = (gnt_rsp.b_valid & cur_req.b_ready) | (gnt_rsp.r_valid & cur_req.r_ready);

    // --------------------------------------------------
    // transaction FSM
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= XB_IDLE;
            grant_q    <= '0;
            prio_q     <= 1'b0;
            is_write_q <= 1'b0;
            decerr_q   <= 1'b0;
            err_rdy_q  <= 1'b0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
        end else begin
            unique case (state_q)
                XB_IDLE: begin
                    if (|pend) begin
                        grant_q      <= '0;
                        grant_q[sel] <= 1'b1;
                        prio_q       <= ~sel;  // other master favoured next
                        is_write_q   <= cur_wr;
                        decerr_q     <= ~in_range;
                        err_rdy_q    <= 1'b0;
                        aw_done_q    <= 1'b0;
                        w_done_q     <= 1'b0;
                        state_q      <= cur_wr ? XB_WRITE : XB_READ;
                    end
                end
                XB_WRITE: begin
                    if (aw_hs) aw_done_q <= 1'b1;
                    if (w_hs) w_done_q <= 1'b1;
                    if ((aw_done_q | aw_hs) && (w_done_q | w_hs)) state_q <= XB_RESP;
                end
                XB_READ: begin
                    if (ar_hs) state_q <= XB_RESP;
                end
                XB_RESP: begin
                    err_rdy_q <= decerr_q;  // answer shows one cycle into RESP
                    if (done) begin
                        state_q <= XB_IDLE;
                        grant_q <= '0;
                    end
                end
                default: state_q <= XB_IDLE;
            endcase
        end
    end

    // never both masters talking at once
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((|{m0_rsp_o.aw_ready, m0_rsp_o.w_ready, m0_rsp_o.ar_ready, m0_rsp_o.b_valid,
             m0_rsp_o.r_valid}) &&
          (|{m1_rsp_o.aw_ready, m1_rsp_o.w_ready, m1_rsp_o.ar_ready, m1_rsp_o.b_valid,
             m1_rsp_o.r_valid})));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == XB_IDLE |-> !(mem_req_o.aw_valid || mem_req_o.w_valid || mem_req_o.ar_valid));

endmodule

// File: rtl/kerbin_reset_seq.sv
// reset sequencer: waits for stable clock lock, then releases the bus reset and later the core reset
`timescale 1ns/1ns

module kerbin_reset_seq (
    input  logic clk_i,
    input  logic rst_n_i,       // board reset
    input  logic lock_i,        // clock manager locked
    output logic rst_bus_n_o,
    output logic rst_core_n_o
);
    import kerbin_pkg::*;

    rst_state_e                 state_q;
    logic [K_RST_CNT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RST_HOLD;
            cnt_q   <= '0;
        end else if (!lock_i) begin
            state_q <= RST_HOLD;  // lost lock, pull everything back
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                RST_HOLD: begin
                    if (int'(cnt_q) == K_LOCK_HOLD_CYCLES) begin
                        state_q <= RST_BUS_UP;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;  // first lock edge counts as zero
                    end
                end
                RST_BUS_UP: begin
                    if (int'(cnt_q) == K_CORE_DELAY_CYCLES - 1) begin
                        state_q <= RST_RUN;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RST_RUN: state_q <= RST_RUN;  // stay released while locked
                default: state_q <= RST_HOLD;
            endcase
        end
    end

    assign rst_bus_n_o  = (state_q != RST_HOLD);
    assign rst_core_n_o = (state_q == RST_RUN);

    // core only comes up after the bus has been out of reset for the full delay
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(rst_core_n_o) |-> rst_bus_n_o && $past(rst_bus_n_o, K_CORE_DELAY_CYCLES));

endmodule

// File: rtl/kerbin_pkg.sv
// shared widths, address map, reset timing and AXI4-Lite channel types, imported by every RTL file
package kerbin_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------
    localparam int K_ADDR_WIDTH = 32;
    localparam int K_DATA_WIDTH = 32;
    localparam int K_STRB_WIDTH = K_DATA_WIDTH / 8;  // one strobe per byte

    typedef logic [K_ADDR_WIDTH-1:0] addr_t;
    typedef logic [K_DATA_WIDTH-1:0] data_t;
    typedef logic [K_STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]              resp_t;

    localparam resp_t K_RESP_OKAY   = 2'b00;
    localparam resp_t K_RESP_DECERR = 2'b11;

    // --------------------------------------------------
    // address map and fabric size
    // --------------------------------------------------
    localparam addr_t K_MEM_BASE       = 32'h0000_0000;
    localparam int    K_MEM_WORDS      = 1024;          // 4 KiB of words
    localparam addr_t K_MEM_END        = 32'h0000_0FFF;  // last byte of memory
    localparam int    K_MEM_IDX_WIDTH  = $clog2(K_MEM_WORDS);
    localparam int    K_NR_MASTERS     = 2;             // instr and data port

    // --------------------------------------------------
    // reset timing
    // --------------------------------------------------
    localparam int K_LOCK_HOLD_CYCLES  = 16;  // stable lock before bus release
    localparam int K_CORE_DELAY_CYCLES = 8;   // bus release to core release
    localparam int K_RST_CNT_WIDTH     = $clog2(K_LOCK_HOLD_CYCLES + 1);

    // master to slave direction
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    // slave to master direction
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_rsp_t;

    typedef enum logic [1:0] {RST_HOLD, RST_BUS_UP, RST_RUN} rst_state_e;
    typedef enum logic [1:0] {XB_IDLE, XB_WRITE, XB_READ, XB_RESP} xbar_state_e;

endpackage
